// File: Bender.yml
package:
  name: dw_shift

sources:
  - dw_cfg_pkg.sv
  - dw_stream_pkg.sv
  - dw_user_decode.sv
  - dw_member_shift.sv
  - dw_stride_select.sv
  - dw_out_slice.sv
  - dw_shift_top.sv
  - target: test
    files:
      - dw_shift_assert.sv
      - tb_dw_shift.sv

// File: all.f
dw_cfg_pkg.sv
dw_stream_pkg.sv
dw_user_decode.sv
dw_member_shift.sv
dw_stride_select.sv
dw_out_slice.sv
dw_shift_top.sv
dw_shift_assert.sv
tb_dw_shift.sv

// File: dw_cfg_pkg.sv
package dw_cfg_pkg;

  //////////////////////////////////////////////////
  // Default sizing of one serializer
  //////////////////////////////////////////////////

  parameter int DEF_UNITS      = 4;   // Words per member vector
  parameter int DEF_WORD_WIDTH = 16;  // Accumulator word
  parameter int DEF_MEMBERS    = 12;  // Member vectors per input beat

  //////////////////////////////////////////////////
  // Kernel and stride limits
  //////////////////////////////////////////////////

  // kw2 is the kernel half-width, 1 to 3 for a 3, 5 or 7 wide kernel
  parameter int KW_MAX = 7;
  // sw_1 is stride minus one
  parameter int SW_MAX = 4;

  //////////////////////////////////////////////////
  // User field widths
  //////////////////////////////////////////////////

  parameter int BITS_KW2       = 2;
  parameter int BITS_SW        = 2;
  parameter int BITS_CLR       = 3;  // Clear field per member
  parameter int BITS_OUT_SHIFT = 2;  // shift_b count

  // Base carries kw2 and sw_1 in its low bits, the rest passes through
  parameter int BASE_WIDTH = 8;

endpackage

// File: dw_member_shift.sv
module dw_member_shift #(
  parameter int MEMBERS    = dw_cfg_pkg::DEF_MEMBERS,
  parameter int UNITS      = dw_cfg_pkg::DEF_UNITS,
  parameter int WORD_WIDTH = dw_cfg_pkg::DEF_WORD_WIDTH,
  localparam int BITS_MEMBERS = $clog2(MEMBERS),
  localparam int BITS_PERIOD  = $clog2(dw_cfg_pkg::KW_MAX + dw_cfg_pkg::SW_MAX)
) (
  input  logic aclk,
  input  logic rst_n,

  input  logic                                          s_valid,
  output logic                                          s_ready,
  input  logic [MEMBERS-1:0][UNITS-1:0][WORD_WIDTH-1:0] s_data,
  input  logic                                          s_last,
  input  logic [BITS_MEMBERS-1:0]                       shift_a,
  input  logic [dw_cfg_pkg::BITS_OUT_SHIFT-1:0]         shift_b,
  input  logic [BITS_PERIOD-1:0]                        period,
  input  logic [MEMBERS-1:0][dw_cfg_pkg::BITS_CLR-1:0]  clr,
  input  logic [dw_cfg_pkg::BASE_WIDTH-1:0]             base,

  output logic                                          a_valid,
  output logic [MEMBERS-1:0][UNITS-1:0][WORD_WIDTH-1:0] a_view,
  output logic [MEMBERS-1:0][dw_cfg_pkg::BITS_CLR-1:0]  a_clr,
  output logic                                          a_last,
  output logic [dw_cfg_pkg::BITS_OUT_SHIFT-1:0]         a_shift_b,
  output logic [BITS_PERIOD-1:0]                        a_period,
  output logic [dw_cfg_pkg::BASE_WIDTH-1:0]             a_base,
  input  logic                                          a_ready
);

  logic [BITS_MEMBERS-1:0] count_a;
  logic                    count_a_last, count_a_en;
  logic                    load;
  logic                    last_q;

  //////////////////////////////////////////////////
  // Step counter
  //////////////////////////////////////////////////

  assign count_a_last = (count_a == '0);
  assign count_a_en   = a_ready & (count_a_last ? s_valid : 1'b1);
  assign s_ready      = a_ready & count_a_last;  // No new beat while steps remain
  assign load         = s_valid & s_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      count_a <= '0;
      a_valid <= 1'b0;
    end else begin
      if (count_a_en)
        count_a <= count_a_last ? shift_a : count_a - 1'b1;
      if (s_ready)
        a_valid <= s_valid;  // Held high through the remaining steps
    end
  end

  //////////////////////////////////////////////////
  // Member register, moved up one member per step
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (count_a_en) begin
      if (count_a_last) begin
        a_view <= s_data;
        a_clr  <= clr;
      end else begin
        a_view <= a_view << (UNITS * WORD_WIDTH);  // Zero enters at member 0
        a_clr  <= a_clr << dw_cfg_pkg::BITS_CLR;
      end
    end
    if (load) begin
      last_q    <= s_last;
      a_shift_b <= shift_b;
      a_period  <= period;
      a_base    <= base;
    end
  end

  assign a_last = last_q & count_a_last;

endmodule

// File: dw_out_slice.sv
module dw_out_slice #(
  parameter int WIDTH      = 64,
  parameter int USER_WIDTH = 11
) (
  input  logic aclk,
  input  logic rst_n,

  input  logic                  b_valid,
  input  logic [WIDTH-1:0]      b_data,
  input  logic [USER_WIDTH-1:0] b_user,
  input  logic                  b_last,
  output logic                  b_ready,

  output logic                  m_valid,
  output logic [WIDTH-1:0]      m_data,
  output logic [USER_WIDTH-1:0] m_user,
  output logic                  m_last,
  input  logic                  m_ready
);

  dw_stream_pkg::slice_state_e state, state_next;

  logic                  in_fire, out_fire;
  logic                  load_main, load_skid, main_from_skid;
  logic [WIDTH-1:0]      skid_data;
  logic [USER_WIDTH-1:0] skid_user;
  logic                  skid_last;

  assign in_fire  = b_valid & b_ready;
  assign out_fire = m_valid & m_ready;
  assign m_valid  = (state != dw_stream_pkg::SLICE_EMPTY);

  always_comb begin
    state_next     = state;
    load_main      = 1'b0;
    load_skid      = 1'b0;
    main_from_skid = 1'b0;
    case (state)
      dw_stream_pkg::SLICE_EMPTY: begin
        if (in_fire) begin
          state_next = dw_stream_pkg::SLICE_ONE;
          load_main  = 1'b1;
        end
      end
      dw_stream_pkg::SLICE_ONE: begin
        if (in_fire && !out_fire) begin  // Consumer stalled, park in skid
          state_next = dw_stream_pkg::SLICE_TWO;
          load_skid  = 1'b1;
        end else if (in_fire) begin
          load_main = 1'b1;
        end else if (out_fire) begin
          state_next = dw_stream_pkg::SLICE_EMPTY;
        end
      end
      dw_stream_pkg::SLICE_TWO: begin
        if (out_fire) begin
          state_next     = dw_stream_pkg::SLICE_ONE;
          main_from_skid = 1'b1;
        end
      end
      default: state_next = dw_stream_pkg::SLICE_EMPTY;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state   <= dw_stream_pkg::SLICE_EMPTY;
      b_ready <= 1'b0;
    end else begin
      state   <= state_next;
      b_ready <= (state_next != dw_stream_pkg::SLICE_TWO);  // No path from m_ready
    end
  end

  always_ff @(posedge aclk) begin
    if (load_main) begin
      m_data <= b_data;
      m_user <= b_user;
      m_last <= b_last;
    end else if (main_from_skid) begin
      m_data <= skid_data;
      m_user <= skid_user;
      m_last <= skid_last;
    end
    if (load_skid) begin
      skid_data <= b_data;
      skid_user <= b_user;
      skid_last <= b_last;
    end
  end

endmodule

// File: dw_shift_assert.sv
module dw_shift_assert #(
  parameter int DATA_W   = 768,
  parameter int USER_IN  = 50,
  parameter int OUT_W    = 64,
  parameter int USER_OUT = 11
) (
  input logic                        aclk,
  input logic                        rst_n,
  input logic                        s_valid,
  input logic                        s_ready,
  input logic [DATA_W-1:0]           s_data,
  input logic [USER_IN-1:0]          s_user,
  input logic                        s_last,
  input logic                        m_valid,
  input logic                        m_ready,
  input logic [OUT_W-1:0]            m_data,
  input logic [USER_OUT-1:0]         m_user,
  input logic                        m_last,
  input logic                        cfg_error,
  input dw_stream_pkg::slice_state_e slice_state,
  input logic                        b_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // Producer side holds its beat until taken, counted from the first edge out of reset
  a_s_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    rst_n && s_valid && !s_ready |=>
      s_valid && $stable(s_data) && $stable(s_user) && $stable(s_last))
    else begin
      $error("Input stream changed while stalled");
      fail_count++;
    end

  a_m_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_user) && $stable(m_last))
    else begin
      $error("Output stream changed while stalled");
      fail_count++;
    end

  a_reset: assert property (@(posedge aclk) !rst_n |=> !m_valid)
    else begin
      $error("m_valid high after reset");
      fail_count++;
    end

  a_skid: assert property (@(posedge aclk) disable iff (!rst_n)
    slice_state == dw_stream_pkg::SLICE_TWO |-> !b_ready)
    else begin
      $error("Slice full but still ready");
      fail_count++;
    end

  a_cfg: assert property (@(posedge aclk) disable iff (!rst_n)
    s_valid && s_ready |-> !cfg_error)
    else begin
      $error("Accepted beat with an unsupported code");
      fail_count++;
    end

endmodule

bind dw_shift_top dw_shift_assert #(
  .DATA_W   (MEMBERS * UNITS * WORD_WIDTH),
  .USER_IN  (USER_IN),
  .OUT_W    (UNITS * WORD_WIDTH),
  .USER_OUT (USER_OUT)
) u_assert (
  .aclk        (aclk),
  .rst_n       (rst_n),
  .s_valid     (s_valid),
  .s_ready     (s_ready),
  .s_data      (s_data),
  .s_user      (s_user),
  .s_last      (s_last),
  .m_valid     (m_valid),
  .m_ready     (m_ready),
  .m_data      (m_data),
  .m_user      (m_user),
  .m_last      (m_last),
  .cfg_error   (cfg_error),
  .slice_state (u_slice.state),
  .b_ready     (b_ready)
);

// File: dw_shift_input.txt
# T name duty timing | I tag base shift_a shift_b clr_octal last (clr digit i from right is member i)
# E member clr base last (member 99 is a zero member) | C base expected_cfg_error
C 0c 1
C 06 0
T single 100 0
I 11 a1 0 0 765432107654 0
E 2 6 a1 0
I 12 56 0 0 765432107654 1
E 5 1 56 1
T expand_k3s2 100 0
I 21 35 1 2 765432107654 1
E 3 7 35 0
E 7 3 35 0
E 11 7 35 0
E 2 6 35 0
E 6 2 35 0
E 10 6 35 1
T expand_k7s1 100 0
I 31 93 2 1 765432107654 0
E 6 2 93 0
E 99 0 93 0
E 5 1 93 0
E 99 0 93 0
E 4 0 93 0
E 99 0 93 0
I 32 93 0 1 765432107654 1
E 6 2 93 0
E 99 0 93 1
T expand_k3s4 100 0
I 41 0d 5 1 012345670123 1
E 5 6 0d 0
E 11 0 0d 0
E 4 7 0d 0
E 10 1 0d 0
E 3 0 0d 0
E 9 2 0d 0
E 2 1 0d 0
E 8 3 0d 0
E 1 2 0d 0
E 7 4 0d 0
E 0 3 0d 0
E 6 5 0d 1
T backpressure 40 0
I 21 35 1 2 765432107654 0
E 3 7 35 0
E 7 3 35 0
E 11 7 35 0
E 2 6 35 0
E 6 2 35 0
E 10 6 35 0
I 51 21 3 0 765432107654 1
E 2 6 21 0
E 1 5 21 0
E 0 4 21 0
E 99 0 21 1
T latency 100 1
I 61 72 1 1 765432107654 1
E 4 0 72 0
E 9 5 72 0
E 3 7 72 0
E 8 4 72 1

// File: dw_shift_top.sv
module dw_shift_top #(
  parameter int MEMBERS    = dw_cfg_pkg::DEF_MEMBERS,
  parameter int UNITS      = dw_cfg_pkg::DEF_UNITS,
  parameter int WORD_WIDTH = dw_cfg_pkg::DEF_WORD_WIDTH,
  localparam int BITS_MEMBERS = $clog2(MEMBERS),
  localparam int USER_IN      = MEMBERS * dw_cfg_pkg::BITS_CLR
                              + dw_cfg_pkg::BITS_OUT_SHIFT
                              + BITS_MEMBERS + dw_cfg_pkg::BASE_WIDTH,
  localparam int USER_OUT     = dw_cfg_pkg::BITS_CLR + dw_cfg_pkg::BASE_WIDTH
) (
  input  logic aclk,
  input  logic rst_n,

  input  logic                                          s_valid,
  output logic                                          s_ready,
  input  logic [MEMBERS-1:0][UNITS-1:0][WORD_WIDTH-1:0] s_data,
  input  logic [USER_IN-1:0]                            s_user,
  input  logic                                          s_last,

  output logic                                          m_valid,
  input  logic                                          m_ready,
  output logic [UNITS-1:0][WORD_WIDTH-1:0]              m_data,
  output logic [USER_OUT-1:0]                           m_user,
  output logic                                          m_last,

  output logic                                          cfg_error
);

  localparam int BITS_PERIOD = $clog2(dw_cfg_pkg::KW_MAX + dw_cfg_pkg::SW_MAX);

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  logic [BITS_MEMBERS-1:0]                      shift_a;
  logic [dw_cfg_pkg::BITS_OUT_SHIFT-1:0]        shift_b;
  logic [BITS_PERIOD-1:0]                       period;
  logic [MEMBERS-1:0][dw_cfg_pkg::BITS_CLR-1:0] clr;
  logic [dw_cfg_pkg::BASE_WIDTH-1:0]            base;

  dw_user_decode #(
    .MEMBERS   (MEMBERS)
  ) u_decode (
    .user      (s_user),
    .valid     (s_valid),
    .shift_a   (shift_a),
    .shift_b   (shift_b),
    .period    (period),
    .clr       (clr),
    .base      (base),
    .cfg_error (cfg_error)
  );

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////

  logic                                          a_valid, a_ready, a_last;
  logic [MEMBERS-1:0][UNITS-1:0][WORD_WIDTH-1:0] a_view;
  logic [MEMBERS-1:0][dw_cfg_pkg::BITS_CLR-1:0]  a_clr;
  logic [dw_cfg_pkg::BITS_OUT_SHIFT-1:0]         a_shift_b;
  logic [BITS_PERIOD-1:0]                        a_period;
  logic [dw_cfg_pkg::BASE_WIDTH-1:0]             a_base;

  logic                                          b_valid, b_ready, b_last;
  logic [UNITS-1:0][WORD_WIDTH-1:0]              b_data;
  logic [USER_OUT-1:0]                           b_user;

  dw_member_shift #(
    .MEMBERS    (MEMBERS),
    .UNITS      (UNITS),
    .WORD_WIDTH (WORD_WIDTH)
  ) u_stage_a (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_data    (s_data),
    .s_last    (s_last),
    .shift_a   (shift_a),
    .shift_b   (shift_b),
    .period    (period),
    .clr       (clr),
    .base      (base),
    .a_valid   (a_valid),
    .a_view    (a_view),
    .a_clr     (a_clr),
    .a_last    (a_last),
    .a_shift_b (a_shift_b),
    .a_period  (a_period),
    .a_base    (a_base),
    .a_ready   (a_ready)
  );

  dw_stride_select #(
    .MEMBERS    (MEMBERS),
    .UNITS      (UNITS),
    .WORD_WIDTH (WORD_WIDTH)
  ) u_stage_b (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .a_valid   (a_valid),
    .a_view    (a_view),
    .a_clr     (a_clr),
    .a_last    (a_last),
    .a_shift_b (a_shift_b),
    .a_period  (a_period),
    .a_base    (a_base),
    .a_ready   (a_ready),
    .b_valid   (b_valid),
    .b_data    (b_data),
    .b_user    (b_user),
    .b_last    (b_last),
    .b_ready   (b_ready)
  );

  // Result
  dw_out_slice #(
    .WIDTH      (UNITS * WORD_WIDTH),
    .USER_WIDTH (USER_OUT)
  ) u_slice (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .b_valid (b_valid),
    .b_data  (b_data),
    .b_user  (b_user),
    .b_last  (b_last),
    .b_ready (b_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_user  (m_user),
    .m_last  (m_last),
    .m_ready (m_ready)
  );

endmodule

// File: dw_stream_pkg.sv
package dw_stream_pkg;

  //////////////////////////////////////////////////
  // Positions inside the base field
  //////////////////////////////////////////////////

  // Lowest bits hold the kernel half-width code
  parameter int I_KW2 = 0;

  // Stride code sits right above kw2
  parameter int I_SW = dw_cfg_pkg::BITS_KW2;

  // Everything above I_SW + BITS_SW is free and travels untouched

  //////////////////////////////////////////////////
  // Output slice
  //////////////////////////////////////////////////

  // Number of beats held in the two-entry output register
  typedef enum logic [1:0] {
    SLICE_EMPTY = 2'd0,  // Nothing held, m_valid low
    SLICE_ONE   = 2'd1,  // Main register full
    SLICE_TWO   = 2'd2   // Main and skid full, input stalled
  } slice_state_e;

  // User word layout
  //   in  : {clr[MEMBERS], shift_b, shift_a, base}
  //   out : {clr of emitted member, base}
  // Both widths scale with MEMBERS, so modules derive them locally

endpackage

// File: dw_stride_select.sv
module dw_stride_select #(
  parameter int MEMBERS    = dw_cfg_pkg::DEF_MEMBERS,
  parameter int UNITS      = dw_cfg_pkg::DEF_UNITS,
  parameter int WORD_WIDTH = dw_cfg_pkg::DEF_WORD_WIDTH,
  localparam int BITS_PERIOD = $clog2(dw_cfg_pkg::KW_MAX + dw_cfg_pkg::SW_MAX),
  localparam int USER_OUT    = dw_cfg_pkg::BITS_CLR + dw_cfg_pkg::BASE_WIDTH
) (
  input  logic aclk,
  input  logic rst_n,

  input  logic                                          a_valid,
  input  logic [MEMBERS-1:0][UNITS-1:0][WORD_WIDTH-1:0] a_view,
  input  logic [MEMBERS-1:0][dw_cfg_pkg::BITS_CLR-1:0]  a_clr,
  input  logic                                          a_last,
  input  logic [dw_cfg_pkg::BITS_OUT_SHIFT-1:0]         a_shift_b,
  input  logic [BITS_PERIOD-1:0]                        a_period,
  input  logic [dw_cfg_pkg::BASE_WIDTH-1:0]             a_base,
  output logic                                          a_ready,

  output logic                                          b_valid,
  output logic [UNITS-1:0][WORD_WIDTH-1:0]              b_data,
  output logic [USER_OUT-1:0]                           b_user,
  output logic                                          b_last,
  input  logic                                          b_ready
);

  localparam int SEL   = MEMBERS / 3;  // Smallest period is 3
  localparam int P_MIN = 3;
  localparam int P_MAX = dw_cfg_pkg::KW_MAX + dw_cfg_pkg::SW_MAX - 1;

  logic [SEL-1:0][UNITS-1:0][WORD_WIDTH-1:0] sel_next, sel_data;
  logic [SEL-1:0][dw_cfg_pkg::BITS_CLR-1:0]  sel_clr_next, sel_clr;
  logic [dw_cfg_pkg::BITS_OUT_SHIFT-1:0]     count_b;
  logic                                      count_b_last, count_b_en;
  logic                                      last_q;
  logic [dw_cfg_pkg::BASE_WIDTH-1:0]         base_q;

  //////////////////////////////////////////////////
  // Period-aligned pick from the stage-A view
  //////////////////////////////////////////////////

  always_comb begin
    sel_next     = '0;
    sel_clr_next = '0;
    for (int p = P_MIN; p <= P_MAX; p++) begin
      if (a_period == p) begin
        for (int q = 0; q < SEL; q++) begin
          if (q * p + p - 1 < MEMBERS) begin
            sel_next[q]     = a_view[q*p+p-1];
            sel_clr_next[q] = a_clr[q*p+p-1];
          end
        end
      end
    end
  end

  // Counter
  assign count_b_last = (count_b == '0);
  assign count_b_en   = b_ready & (count_b_last ? a_valid : 1'b1);
  assign a_ready      = b_ready & count_b_last;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      count_b <= '0;
      b_valid <= 1'b0;
    end else begin
      if (count_b_en)
        count_b <= count_b_last ? a_shift_b : count_b - 1'b1;
      if (a_ready)
        b_valid <= a_valid;
    end
  end

  // Selection shifts down, member 0 is always the one on the bus
  always_ff @(posedge aclk) begin
    if (count_b_en) begin
      sel_data <= count_b_last ? sel_next : sel_data >> (UNITS * WORD_WIDTH);
      sel_clr  <= count_b_last ? sel_clr_next : sel_clr >> dw_cfg_pkg::BITS_CLR;
    end
    if (a_valid & a_ready) begin
      last_q <= a_last;
      base_q <= a_base;
    end
  end

  assign b_data = sel_data[0];
  assign b_user = {sel_clr[0], base_q};
  assign b_last = last_q & count_b_last;  // Only on the final pick

endmodule

// File: dw_user_decode.sv
module dw_user_decode #(
  parameter int MEMBERS = dw_cfg_pkg::DEF_MEMBERS,
  localparam int BITS_MEMBERS = $clog2(MEMBERS),
  localparam int BITS_PERIOD  = $clog2(dw_cfg_pkg::KW_MAX + dw_cfg_pkg::SW_MAX),
  localparam int USER_WIDTH   = MEMBERS * dw_cfg_pkg::BITS_CLR
                              + dw_cfg_pkg::BITS_OUT_SHIFT
                              + BITS_MEMBERS + dw_cfg_pkg::BASE_WIDTH
) (
  input  logic [USER_WIDTH-1:0]                         user,
  input  logic                                          valid,
  output logic [BITS_MEMBERS-1:0]                       shift_a,
  output logic [dw_cfg_pkg::BITS_OUT_SHIFT-1:0]         shift_b,
  output logic [BITS_PERIOD-1:0]                        period,
  output logic [MEMBERS-1:0][dw_cfg_pkg::BITS_CLR-1:0]  clr,
  output logic [dw_cfg_pkg::BASE_WIDTH-1:0]             base,
  output logic                                          cfg_error
);

  logic [dw_cfg_pkg::BITS_KW2-1:0] kw2;
  logic [dw_cfg_pkg::BITS_SW-1:0]  sw_1;

  // Clear fields on top, base at the bottom
  assign {clr, shift_b, shift_a, base} = user;

  assign kw2  = base[dw_stream_pkg::I_KW2 +: dw_cfg_pkg::BITS_KW2];
  assign sw_1 = base[dw_stream_pkg::I_SW +: dw_cfg_pkg::BITS_SW];

  // Kernel width plus stride minus one
  assign period = BITS_PERIOD'(2 * kw2 + 1 + sw_1);

  // kw2 of zero is the width-one kernel, which has no path here
  assign cfg_error = valid & ((kw2 == '0) | (period > MEMBERS));

endmodule

// File: tb_dw_shift.sv
module tb_dw_shift;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEMBERS      = dw_cfg_pkg::DEF_MEMBERS;
  localparam int UNITS        = dw_cfg_pkg::DEF_UNITS;
  localparam int WORD_WIDTH   = dw_cfg_pkg::DEF_WORD_WIDTH;
  localparam int BITS_MEMBERS = $clog2(MEMBERS);
  localparam int CLR_W        = MEMBERS * dw_cfg_pkg::BITS_CLR;
  localparam int USER_IN      = CLR_W + dw_cfg_pkg::BITS_OUT_SHIFT
                              + BITS_MEMBERS + dw_cfg_pkg::BASE_WIDTH;
  localparam int USER_OUT     = dw_cfg_pkg::BITS_CLR + dw_cfg_pkg::BASE_WIDTH;
  localparam int ZERO_MEMBER  = 99;  // Marks a member that was shifted in or picked out of range

  logic                                          aclk, rst_n;
  logic                                          s_valid, s_ready, s_last;
  logic [MEMBERS-1:0][UNITS-1:0][WORD_WIDTH-1:0] s_data;
  logic [USER_IN-1:0]                            s_user;
  logic                                          m_valid, m_ready, m_last;
  logic [UNITS-1:0][WORD_WIDTH-1:0]              m_data;
  logic [USER_OUT-1:0]                           m_user;
  logic                                          cfg_error;

  // Vectors from the data file
  string                                     test_name[$];
  int                                        test_duty[$], test_timing[$];
  int                                        test_in_first[$], test_in_cnt[$];
  int                                        test_ex_first[$], test_ex_cnt[$];
  logic [7:0]                                in_tag[$], in_base[$];
  logic [BITS_MEMBERS-1:0]                   in_sa[$];
  logic [dw_cfg_pkg::BITS_OUT_SHIFT-1:0]     in_sb[$];
  logic [CLR_W-1:0]                          in_clr[$];
  logic                                      in_last[$];
  int                                        ex_mem[$];
  logic [7:0]                                ex_tag[$], ex_base[$];
  logic [dw_cfg_pkg::BITS_CLR-1:0]           ex_clr[$];
  logic                                      ex_last[$];
  logic [7:0]                                cfg_base[$];
  logic                                      cfg_err[$];

  int cyc = 0;
  int duty = 100;
  int accept_cyc;
  int limit_cycles = 0;
  int error_count = 0;
  int check_count = 0;
  int test_errors;

  dw_shift_top #(
    .MEMBERS    (MEMBERS),
    .UNITS      (UNITS),
    .WORD_WIDTH (WORD_WIDTH)
  ) DUT (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_data    (s_data),
    .s_user    (s_user),
    .s_last    (s_last),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_data    (m_data),
    .m_user    (m_user),
    .m_last    (m_last),
    .cfg_error (cfg_error)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  always @(posedge aclk) cyc <= cyc + 1;

  // Consumer back-pressure, duty in percent
  initial begin : ready_gen
    int unsigned r;
    r = $urandom(80422);
    m_ready = 1'b0;
    forever begin
      @(posedge aclk);
      r = $urandom % 100;
      m_ready <= (r < duty);
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge aclk);
    $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Vector file and beat patterns
  //////////////////////////////////////////////////

  task automatic load_vectors();
    int        fd, n, a, b, c, d, e;
    string     line, kind, name;
    logic [CLR_W-1:0] clr_v;
    logic [7:0] cur_tag;
    fd = $fopen("dw_shift_input.txt", "r");
    cur_tag = '0;
    if (fd == 0) begin
      $display("Cannot open the vector file dw_shift_input.txt");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        kind = "";
        if (n > 0)
          n = $sscanf(line, "%s", kind);
        if (kind == "T") begin
          n = $sscanf(line, "%s %s %d %d", kind, name, a, b);
          test_name.push_back(name);
          test_duty.push_back(a);
          test_timing.push_back(b);
          test_in_first.push_back(in_tag.size());
          test_in_cnt.push_back(0);
          test_ex_first.push_back(ex_mem.size());
          test_ex_cnt.push_back(0);
        end else if (kind == "I") begin
          n = $sscanf(line, "%s %h %h %d %d %o %d", kind, a, b, c, d, clr_v, e);
          cur_tag = a[7:0];
          in_tag.push_back(a[7:0]);
          in_base.push_back(b[7:0]);
          in_sa.push_back(c[BITS_MEMBERS-1:0]);
          in_sb.push_back(d[dw_cfg_pkg::BITS_OUT_SHIFT-1:0]);
          in_clr.push_back(clr_v);
          in_last.push_back(e[0]);
          test_in_cnt[test_in_cnt.size()-1]++;
        end else if (kind == "E") begin
          n = $sscanf(line, "%s %d %d %h %d", kind, a, b, c, d);
          ex_mem.push_back(a);
          ex_clr.push_back(b[dw_cfg_pkg::BITS_CLR-1:0]);
          ex_base.push_back(c[7:0]);
          ex_last.push_back(d[0]);
          ex_tag.push_back(cur_tag);
          test_ex_cnt[test_ex_cnt.size()-1]++;
        end else if (kind == "C") begin
          n = $sscanf(line, "%s %h %d", kind, a, b);
          cfg_base.push_back(a[7:0]);
          cfg_err.push_back(b[0]);
        end
      end
      $fclose(fd);
    end
  endtask

  // Word u of member i is {tag, i, u}
  function automatic logic [MEMBERS-1:0][UNITS-1:0][WORD_WIDTH-1:0] make_beat(
    input logic [7:0] tag
  );
    logic [MEMBERS-1:0][UNITS-1:0][WORD_WIDTH-1:0] beat;
    for (int i = 0; i < MEMBERS; i++)
      for (int u = 0; u < UNITS; u++)
        beat[i][u] = {tag, 4'(i), 4'(u)};
    return beat;
  endfunction

  function automatic logic [UNITS-1:0][WORD_WIDTH-1:0] member_word(
    input logic [7:0] tag,
    input int         mem
  );
    logic [UNITS-1:0][WORD_WIDTH-1:0] w;
    w = '0;
    if (mem != ZERO_MEMBER)
      for (int u = 0; u < UNITS; u++)
        w[u] = {tag, 4'(mem), 4'(u)};
    return w;
  endfunction

  //////////////////////////////////////////////////
  // Stream driver and output monitor
  //////////////////////////////////////////////////

  task automatic drive_inputs(input int t);
    logic accepted;
    for (int k = test_in_first[t]; k < test_in_first[t] + test_in_cnt[t]; k++) begin
      @(posedge aclk);
      s_valid <= 1'b1;
      s_data  <= make_beat(in_tag[k]);
      s_user  <= {in_clr[k], in_sb[k], in_sa[k], in_base[k]};
      s_last  <= in_last[k];
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge aclk);
        accepted = s_ready;  // Transfer on the coming edge
        if (accepted && k == test_in_first[t])
          accept_cyc = cyc;
        if (!accepted)
          @(posedge aclk);
      end
    end
    @(posedge aclk);
    s_valid <= 1'b0;
    s_last  <= 1'b0;
  endtask

  task automatic collect_outputs(input int t);
    logic [UNITS-1:0][WORD_WIDTH-1:0] exp_data;
    logic [USER_OUT-1:0]              exp_user;
    int                               prev;
    prev = 0;
    for (int k = test_ex_first[t]; k < test_ex_first[t] + test_ex_cnt[t]; k++) begin
      do @(negedge aclk); while (!(m_valid && m_ready));
      exp_data = member_word(ex_tag[k], ex_mem[k]);
      exp_user = {ex_clr[k], ex_base[k]};
      check_count += 3;
      assert (m_data == exp_data) else begin
        $display("[FAIL] %s beat %0d m_data: expected %h, actual %h",
                 test_name[t], k - test_ex_first[t], exp_data, m_data);
        test_errors++;
      end
      assert (m_user == exp_user) else begin
        $display("[FAIL] %s beat %0d m_user: expected %h, actual %h",
                 test_name[t], k - test_ex_first[t], exp_user, m_user);
        test_errors++;
      end
      assert (m_last == ex_last[k]) else begin
        $display("[FAIL] %s beat %0d m_last: expected %0b, actual %0b",
                 test_name[t], k - test_ex_first[t], ex_last[k], m_last);
        test_errors++;
      end
      if (test_timing[t] != 0) begin
        check_count++;
        if (k == test_ex_first[t]) begin
          assert (cyc - accept_cyc == 3) else begin  // Stage A, stage B, slice
            $display("[FAIL] %s first beat latency: expected 3, actual %0d",
                     test_name[t], cyc - accept_cyc);
            test_errors++;
          end
        end else begin
          assert (cyc - prev == 1) else begin
            $display("[FAIL] %s beat %0d spacing: expected 1, actual %0d",
                     test_name[t], k - test_ex_first[t], cyc - prev);
            test_errors++;
          end
        end
      end
      prev = cyc;
    end
  endtask

  task automatic check_cfg(input int r);
    check_count++;
    assert (cfg_error == cfg_err[r]) else begin
      $display("[FAIL] cfg_check base %h cfg_error: expected %0b, actual %0b",
               cfg_base[r], cfg_err[r], cfg_error);
      error_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    int total_exp;
    int tests_passed;
    rst_n   = 1'b0;
    s_valid = 1'b0;
    s_data  = '0;
    s_user  = '0;
    s_last  = 1'b0;
    tests_passed = 0;
    load_vectors();
    total_exp = ex_mem.size();
    limit_cycles = total_exp * 8 + 100;

    // Config decode is checked while reset keeps s_ready low
    for (int r = 0; r < 2; r++) begin
      if (r < cfg_base.size()) begin
        s_valid <= 1'b1;
        s_user  <= {{(USER_IN - dw_cfg_pkg::BASE_WIDTH){1'b0}}, cfg_base[r]};
      end
      #5;
      if (r < cfg_base.size())
        check_cfg(r);
      @(posedge aclk);
    end
    rst_n   <= 1'b1;
    s_valid <= 1'b0;
    s_user  <= '0;
    $display("test cfg_check: %0d vectors", cfg_base.size());

    for (int t = 0; t < test_name.size(); t++) begin
      duty = test_duty[t];
      test_errors = 0;
      fork
        drive_inputs(t);
        collect_outputs(t);
      join
      error_count += test_errors;
      if (test_errors == 0)
        tests_passed++;
      $display("test %s: %0d beats, %0d errors", test_name[t], test_ex_cnt[t], test_errors);
    end

    duty = 100;
    repeat (10) begin
      @(negedge aclk);
      assert (!m_valid) else begin
        $display("An output beat appeared after all expected beats were received");
        error_count++;
      end
    end

    if (DUT.u_assert.fail_count != 0) begin
      $display("Bound protocol assertions failed %0d times", DUT.u_assert.fail_count);
      error_count += DUT.u_assert.fail_count;
    end

    $display("tests %0d, passed %0d, checks %0d, errors %0d",
             test_name.size(), tests_passed, check_count, error_count);
    if (error_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
